// ==== design/lrq_config.svh ====
`ifndef LRQ_CONFIG_SVH
`define LRQ_CONFIG_SVH

// --------------------------------------------------
// queue geometry
// --------------------------------------------------

// number of miss entries
`define LRQ_ENTRIES 4

// physical address width
`define LRQ_PADDR_W 32

// L1D line size in bytes
`define LRQ_LINE_BYTES 16

// --------------------------------------------------
// external tag layout
// --------------------------------------------------

// full tag width on the external read bus
`define LRQ_TAG_W 6

// unit code in the top two tag bits, marks reads from this unit
`define LRQ_TAG_UPPER_RD_L1D 2'b01

`endif

// ==== design/lrq_pkg.sv ====
`default_nettype none

`include "lrq_config.svh"

package lrq_pkg;

  // --------------------------------------------------
  // address and data vectors
  // --------------------------------------------------
  typedef logic [`LRQ_PADDR_W-1:0] paddr_t;

  // address with the line offset bits stripped
  typedef logic [`LRQ_PADDR_W-$clog2(`LRQ_LINE_BYTES)-1:0] line_addr_t;

  typedef logic [`LRQ_LINE_BYTES*8-1:0] line_data_t;

  // --------------------------------------------------
  // entry bookkeeping
  // --------------------------------------------------

  // one bit per entry, one-hot or mask
  typedef logic [`LRQ_ENTRIES-1:0] entry_vec_t;
  typedef logic [$clog2(`LRQ_ENTRIES)-1:0] entry_idx_t;

  // unit code, zero filler, entry number
  typedef logic [`LRQ_TAG_W-1:0] ext_tag_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_WAIT_RESP,
    ST_WRITE
  } entry_state_t;

endpackage

`default_nettype wire

// ==== design/lrq_alloc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lrq_config.svh"

module lrq_alloc (
  input  wire logic                i_req_valid,
  input  wire lrq_pkg::paddr_t     i_req_paddr,
  input  wire lrq_pkg::entry_vec_t i_entry_valid,
  input  wire lrq_pkg::line_addr_t i_entry_line [`LRQ_ENTRIES],
  input  wire lrq_pkg::entry_vec_t i_wr_grant_oh,
  output lrq_pkg::entry_vec_t      o_alloc_oh,
  output logic                     o_req_conflict,
  output logic                     o_req_full,
  output lrq_pkg::entry_vec_t      o_req_index_oh
);

  import lrq_pkg::*;

  // offset bits dropped from the request address
  localparam int OFFSET_W = $bits(paddr_t) - $bits(line_addr_t);

  line_addr_t w_req_line;
  entry_vec_t w_match;
  entry_vec_t w_match_oh;
  entry_vec_t w_free;
  entry_vec_t w_free_oh;

  assign w_req_line = i_req_paddr[$bits(paddr_t)-1:OFFSET_W];

  // --------------------------------------------------
  // same-line check against live entries
  // --------------------------------------------------

  // an entry granted its write this cycle is already leaving
  always_comb begin
    for (int e = 0; e < `LRQ_ENTRIES; e++) begin
      w_match[e] = i_entry_valid[e] & ~i_wr_grant_oh[e] &
                   (i_entry_line[e] == w_req_line);
    end
  end

  assign w_match_oh = w_match & (~w_match + entry_vec_t'(1));

  // --------------------------------------------------
  // free entry pick and request response
  // --------------------------------------------------
  assign w_free    = ~i_entry_valid;
  assign w_free_oh = w_free & (~w_free + entry_vec_t'(1));

  always_comb begin
    o_req_conflict = 1'b0;
    o_req_full     = 1'b0;
    o_req_index_oh = '0;
    o_alloc_oh     = '0;
    if (i_req_valid) begin
      if (|w_match) begin
        o_req_conflict = 1'b1;
        o_req_index_oh = w_match_oh;
      end else if (!(|w_free)) begin
        o_req_full = 1'b1;
      end else begin
        o_req_index_oh = w_free_oh;
        o_alloc_oh     = w_free_oh;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/lrq_entry_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lrq_config.svh"

module lrq_entry_array (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire lrq_pkg::entry_vec_t i_alloc_oh,
  input  wire lrq_pkg::paddr_t     i_req_paddr,
  input  wire lrq_pkg::entry_vec_t i_sent_oh,
  input  wire lrq_pkg::entry_vec_t i_fill_oh,
  input  wire lrq_pkg::line_data_t i_fill_data,
  input  wire lrq_pkg::entry_vec_t i_wr_grant_oh,
  output lrq_pkg::entry_vec_t      o_entry_valid,
  output lrq_pkg::entry_vec_t      o_send_mask,
  output lrq_pkg::entry_vec_t      o_write_mask,
  output lrq_pkg::line_addr_t      o_entry_line [`LRQ_ENTRIES],
  output lrq_pkg::line_data_t      o_entry_data [`LRQ_ENTRIES]
);

  import lrq_pkg::*;

  // offset bits dropped from the request address
  localparam int OFFSET_W = $bits(paddr_t) - $bits(line_addr_t);

  line_addr_t w_req_line;

  assign w_req_line = i_req_paddr[$bits(paddr_t)-1:OFFSET_W];

  // --------------------------------------------------
  // per-entry state, line address and data
  // --------------------------------------------------
  for (genvar e = 0; e < `LRQ_ENTRIES; e++) begin : g_entry
    entry_state_t r_state;
    entry_state_t w_state_next;
    line_addr_t   r_line;
    line_data_t   r_data;
    logic         w_load;
    logic         w_fill;

    // alloc only ever targets a free entry, fill only a waiting one
    assign w_load = i_alloc_oh[e] & (r_state == ST_IDLE);
    assign w_fill = i_fill_oh[e] & (r_state == ST_WAIT_RESP);

    always_comb begin
      w_state_next = r_state;
      case (r_state)
        ST_IDLE: begin
          if (i_alloc_oh[e]) begin
            w_state_next = ST_SEND;
          end
        end
        ST_SEND: begin
          if (i_sent_oh[e]) begin
            w_state_next = ST_WAIT_RESP;
          end
        end
        ST_WAIT_RESP: begin
          if (i_fill_oh[e]) begin
            w_state_next = ST_WRITE;
          end
        end
        ST_WRITE: begin
          // line goes back to the pool after the L1D write
          if (i_wr_grant_oh[e]) begin
            w_state_next = ST_IDLE;
          end
        end
        default: begin
          w_state_next = ST_IDLE;
        end
      endcase
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_state <= ST_IDLE;
      end else begin
        r_state <= w_state_next;
      end
    end

    always_ff @(posedge i_clk) begin
      if (w_load) begin
        r_line <= w_req_line;
      end
      if (w_fill) begin
        r_data <= i_fill_data;
      end
    end

    assign o_entry_valid[e] = (r_state != ST_IDLE);
    assign o_send_mask[e]   = (r_state == ST_SEND);
    assign o_write_mask[e]  = (r_state == ST_WRITE);
    assign o_entry_line[e]  = r_line;
    assign o_entry_data[e]  = r_data;
  end

endmodule

`default_nettype wire

// ==== design/lrq_ext_port.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lrq_config.svh"

module lrq_ext_port (
  input  wire lrq_pkg::entry_vec_t i_send_mask,
  input  wire lrq_pkg::entry_vec_t i_write_mask,
  input  wire lrq_pkg::entry_vec_t i_entry_valid,
  input  wire lrq_pkg::line_addr_t i_entry_line [`LRQ_ENTRIES],
  input  wire lrq_pkg::line_data_t i_entry_data [`LRQ_ENTRIES],
  input  wire logic                i_ext_req_ready,
  input  wire logic                i_ext_resp_valid,
  input  wire lrq_pkg::ext_tag_t   i_ext_resp_tag,
  input  wire lrq_pkg::line_data_t i_ext_resp_data,
  output logic                     o_ext_req_valid,
  output lrq_pkg::paddr_t          o_ext_req_paddr,
  output lrq_pkg::ext_tag_t        o_ext_req_tag,
  output lrq_pkg::entry_vec_t      o_sent_oh,
  output lrq_pkg::entry_vec_t      o_fill_oh,
  output lrq_pkg::line_data_t      o_fill_data,
  output logic                     o_wr_valid,
  output lrq_pkg::paddr_t          o_wr_paddr,
  output lrq_pkg::line_data_t      o_wr_data,
  output lrq_pkg::entry_vec_t      o_wr_grant_oh,
  output logic                     o_resolve_valid,
  output lrq_pkg::entry_vec_t      o_resolve_index_oh,
  output logic                     o_lrq_full
);

  import lrq_pkg::*;

  localparam int OFFSET_W   = $bits(paddr_t) - $bits(line_addr_t);
  localparam int TAG_FILL_W = `LRQ_TAG_W - 2 - $bits(entry_idx_t);

  entry_vec_t w_send_oh;
  entry_idx_t w_send_idx;
  line_addr_t w_send_line;
  logic       w_resp_hit;
  entry_idx_t w_resp_idx;
  entry_vec_t w_wr_oh;
  line_addr_t w_wr_line;
  line_data_t w_wr_data;

  function automatic line_addr_t mux_line(entry_vec_t oh, line_addr_t lines [`LRQ_ENTRIES]);
    line_addr_t sel;
    sel = '0;
    for (int e = 0; e < `LRQ_ENTRIES; e++) begin
      if (oh[e]) begin
        sel = lines[e];
      end
    end
    return sel;
  endfunction

  // --------------------------------------------------
  // external line read
  // --------------------------------------------------

  // lowest entry still waiting to go out
  assign w_send_oh = i_send_mask & (~i_send_mask + entry_vec_t'(1));

  always_comb begin
    w_send_idx = '0;
    for (int e = 0; e < `LRQ_ENTRIES; e++) begin
      if (w_send_oh[e]) begin
        w_send_idx = entry_idx_t'(e);
      end
    end
  end

  assign w_send_line     = mux_line(w_send_oh, i_entry_line);
  assign o_ext_req_valid = |i_send_mask;
  assign o_ext_req_paddr = {w_send_line, {OFFSET_W{1'b0}}};
  assign o_ext_req_tag   = {`LRQ_TAG_UPPER_RD_L1D, {TAG_FILL_W{1'b0}}, w_send_idx};
  assign o_sent_oh       = (o_ext_req_valid & i_ext_req_ready) ? w_send_oh : '0;

  // --------------------------------------------------
  // response match and resolve
  // --------------------------------------------------

  // responses for other requesters carry a different unit code
  assign w_resp_hit = i_ext_resp_valid &
                      (i_ext_resp_tag[`LRQ_TAG_W-1 -: 2] == `LRQ_TAG_UPPER_RD_L1D);
  assign w_resp_idx = i_ext_resp_tag[$bits(entry_idx_t)-1:0];

  assign o_fill_oh          = w_resp_hit ? (entry_vec_t'(1) << w_resp_idx) : '0;
  assign o_fill_data        = i_ext_resp_data;
  assign o_resolve_valid    = w_resp_hit;
  assign o_resolve_index_oh = o_fill_oh;

  // --------------------------------------------------
  // L1D fill write
  // --------------------------------------------------
  assign w_wr_oh   = i_write_mask & (~i_write_mask + entry_vec_t'(1));
  assign w_wr_line = mux_line(w_wr_oh, i_entry_line);

  always_comb begin
    w_wr_data = '0;
    for (int e = 0; e < `LRQ_ENTRIES; e++) begin
      if (w_wr_oh[e]) begin
        w_wr_data = i_entry_data[e];
      end
    end
  end

  // write strobe is never refused, so the pick is also the grant
  assign o_wr_valid    = |i_write_mask;
  assign o_wr_paddr    = {w_wr_line, {OFFSET_W{1'b0}}};
  assign o_wr_data     = w_wr_data;
  assign o_wr_grant_oh = w_wr_oh;

  assign o_lrq_full = &i_entry_valid;

endmodule

`default_nettype wire

// ==== design/l1d_miss_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lrq_config.svh"

module l1d_miss_unit (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  // load miss request
  input  wire logic                i_req_valid,
  input  wire lrq_pkg::paddr_t     i_req_paddr,
  output logic                     o_req_conflict,
  output logic                     o_req_full,
  output lrq_pkg::entry_vec_t      o_req_index_oh,
  // external line read
  output logic                     o_ext_req_valid,
  output lrq_pkg::paddr_t          o_ext_req_paddr,
  output lrq_pkg::ext_tag_t        o_ext_req_tag,
  input  wire logic                i_ext_req_ready,
  input  wire logic                i_ext_resp_valid,
  input  wire lrq_pkg::ext_tag_t   i_ext_resp_tag,
  input  wire lrq_pkg::line_data_t i_ext_resp_data,
  // L1D fill write
  output logic                     o_wr_valid,
  output lrq_pkg::paddr_t          o_wr_paddr,
  output lrq_pkg::line_data_t      o_wr_data,
  // resolve and status
  output logic                     o_resolve_valid,
  output lrq_pkg::entry_vec_t      o_resolve_index_oh,
  output logic                     o_lrq_full
);

  import lrq_pkg::*;

  entry_vec_t w_entry_valid;
  entry_vec_t w_send_mask;
  entry_vec_t w_write_mask;
  line_addr_t w_entry_line [`LRQ_ENTRIES];
  line_data_t w_entry_data [`LRQ_ENTRIES];
  entry_vec_t w_alloc_oh;
  entry_vec_t w_sent_oh;
  entry_vec_t w_fill_oh;
  line_data_t w_fill_data;
  entry_vec_t w_wr_grant_oh;

  // --------------------------------------------------
  // decode, execute, result
  // --------------------------------------------------
  lrq_alloc u_lrq_alloc (
    .i_req_valid    (i_req_valid),
    .i_req_paddr    (i_req_paddr),
    .i_entry_valid  (w_entry_valid),
    .i_entry_line   (w_entry_line),
    .i_wr_grant_oh  (w_wr_grant_oh),
    .o_alloc_oh     (w_alloc_oh),
    .o_req_conflict (o_req_conflict),
    .o_req_full     (o_req_full),
    .o_req_index_oh (o_req_index_oh)
  );

  lrq_entry_array u_lrq_entry_array (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_alloc_oh    (w_alloc_oh),
    .i_req_paddr   (i_req_paddr),
    .i_sent_oh     (w_sent_oh),
    .i_fill_oh     (w_fill_oh),
    .i_fill_data   (w_fill_data),
    .i_wr_grant_oh (w_wr_grant_oh),
    .o_entry_valid (w_entry_valid),
    .o_send_mask   (w_send_mask),
    .o_write_mask  (w_write_mask),
    .o_entry_line  (w_entry_line),
    .o_entry_data  (w_entry_data)
  );

  lrq_ext_port u_lrq_ext_port (
    .i_send_mask        (w_send_mask),
    .i_write_mask       (w_write_mask),
    .i_entry_valid      (w_entry_valid),
    .i_entry_line       (w_entry_line),
    .i_entry_data       (w_entry_data),
    .i_ext_req_ready    (i_ext_req_ready),
    .i_ext_resp_valid   (i_ext_resp_valid),
    .i_ext_resp_tag     (i_ext_resp_tag),
    .i_ext_resp_data    (i_ext_resp_data),
    .o_ext_req_valid    (o_ext_req_valid),
    .o_ext_req_paddr    (o_ext_req_paddr),
    .o_ext_req_tag      (o_ext_req_tag),
    .o_sent_oh          (w_sent_oh),
    .o_fill_oh          (w_fill_oh),
    .o_fill_data        (w_fill_data),
    .o_wr_valid         (o_wr_valid),
    .o_wr_paddr         (o_wr_paddr),
    .o_wr_data          (o_wr_data),
    .o_wr_grant_oh      (w_wr_grant_oh),
    .o_resolve_valid    (o_resolve_valid),
    .o_resolve_index_oh (o_resolve_index_oh),
    .o_lrq_full         (o_lrq_full)
  );

endmodule

`default_nettype wire

// ==== test/tb_l1d_miss_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lrq_config.svh"

module tb_l1d_miss_unit;

  import lrq_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int TIMEOUT_CYCLES = 20;
  localparam int OFFSET_W       = $clog2(`LRQ_LINE_BYTES);

  typedef enum logic [1:0] {OP_REQ, OP_SEND, OP_RESP, OP_WRITE} op_t;

  // addr is the request or the expected read address, tag is driven or expected
  typedef struct packed {
    op_t        op;
    paddr_t     addr;
    ext_tag_t   tag;
    line_data_t data;
    logic       ready;
    logic       exp_conflict;
    logic       exp_full;
    entry_vec_t exp_oh;
  } row_t;

  logic       i_clk, i_reset_n, i_req_valid, i_ext_req_ready, i_ext_resp_valid;
  paddr_t     i_req_paddr;
  ext_tag_t   i_ext_resp_tag;
  line_data_t i_ext_resp_data;
  logic       o_req_conflict, o_req_full, o_ext_req_valid, o_wr_valid;
  logic       o_resolve_valid, o_lrq_full;
  entry_vec_t o_req_index_oh, o_resolve_index_oh;
  paddr_t     o_ext_req_paddr, o_wr_paddr;
  ext_tag_t   o_ext_req_tag;
  line_data_t o_wr_data;

  row_t       rows [32];
  int         n_rows;
  // occupied lines as seen from outside
  entry_vec_t model_valid;
  line_addr_t model_line [`LRQ_ENTRIES];

  l1d_miss_unit u_l1d_miss_unit (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_req_valid (i_req_valid), .i_req_paddr (i_req_paddr),
    .o_req_conflict (o_req_conflict), .o_req_full (o_req_full),
    .o_req_index_oh (o_req_index_oh),
    .o_ext_req_valid (o_ext_req_valid), .o_ext_req_paddr (o_ext_req_paddr),
    .o_ext_req_tag (o_ext_req_tag), .i_ext_req_ready (i_ext_req_ready),
    .i_ext_resp_valid (i_ext_resp_valid), .i_ext_resp_tag (i_ext_resp_tag),
    .i_ext_resp_data (i_ext_resp_data),
    .o_wr_valid (o_wr_valid), .o_wr_paddr (o_wr_paddr), .o_wr_data (o_wr_data),
    .o_resolve_valid (o_resolve_valid), .o_resolve_index_oh (o_resolve_index_oh),
    .o_lrq_full (o_lrq_full)
  );

  always #(CLK_PERIOD/2) i_clk = ~i_clk;

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      stop_run();
    end
  endtask

  // poll at each edge until the strobe shows up
  task automatic wait_valid(input bit on_write);
    int cycles;
    cycles = 0;
    #1;
    while (!(on_write ? o_wr_valid : o_ext_req_valid)) begin
      @(posedge i_clk);
      #3;
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("timeout, %s never came", on_write ? "o_wr_valid" : "o_ext_req_valid");
        stop_run();
      end
    end
  endtask

  function automatic entry_idx_t oh_to_idx(input entry_vec_t oh);
    entry_idx_t idx;
    idx = '0;
    for (int e = 0; e < `LRQ_ENTRIES; e++) begin
      if (oh[e]) begin
        idx = entry_idx_t'(e);
      end
    end
    return idx;
  endfunction

  task automatic add_row(input op_t op, input paddr_t addr, input ext_tag_t tag,
                         input line_data_t data, input logic ready, input logic conflict,
                         input logic full, input entry_vec_t oh);
    rows[n_rows] = '{op, addr, tag, data, ready, conflict, full, oh};
    n_rows++;
  endtask

  task automatic build_table();
    line_data_t d;
    d = {$urandom, $urandom, $urandom, $urandom};
    n_rows = 0;
    // --------------------------------------------------
    // fill the queue, then full and same-line conflict
    // --------------------------------------------------
    add_row(OP_REQ, 32'h1000_0047, '0, '0, 0, 0, 0, 4'b0001);
    add_row(OP_REQ, 32'h2000_008c, '0, '0, 0, 0, 0, 4'b0010);
    add_row(OP_REQ, 32'h3000_00c0, '0, '0, 0, 0, 0, 4'b0100);
    add_row(OP_REQ, 32'h4000_0100, '0, '0, 0, 0, 0, 4'b1000);
    add_row(OP_REQ, 32'h5000_0000, '0, '0, 0, 0, 1, 4'b0000);
    add_row(OP_REQ, 32'h3000_00c8, '0, '0, 0, 1, 0, 4'b0100);
    // --------------------------------------------------
    // reads held by ready, then released in order
    // --------------------------------------------------
    add_row(OP_SEND, 32'h1000_0040, 6'b01_00_00, '0, 0, 0, 0, '0);
    add_row(OP_SEND, 32'h1000_0040, 6'b01_00_00, '0, 1, 0, 0, '0);
    add_row(OP_SEND, 32'h2000_0080, 6'b01_00_01, '0, 1, 0, 0, '0);
    add_row(OP_SEND, 32'h3000_00c0, 6'b01_00_10, '0, 1, 0, 0, '0);
    add_row(OP_SEND, 32'h4000_0100, 6'b01_00_11, '0, 1, 0, 0, '0);
    // --------------------------------------------------
    // fill entry 2, foreign response, reuse of entry 2
    // --------------------------------------------------
    add_row(OP_RESP, '0, 6'b01_00_10, d, 0, 0, 0, 4'b0100);
    add_row(OP_WRITE, '0, '0, d, 0, 0, 0, 4'b0100);
    add_row(OP_RESP, '0, 6'b10_00_10, ~d, 0, 0, 0, 4'b0000);
    add_row(OP_REQ, 32'h6000_0000, '0, '0, 0, 0, 0, 4'b0100);
    add_row(OP_REQ, 32'h3000_00c0, '0, '0, 0, 0, 1, 4'b0000);
  endtask

  initial begin
    row_t       r;
    string      name;
    entry_idx_t idx;
    void'($urandom(73));
    i_clk            = 1'b0;
    i_reset_n        = 1'b0;
    i_req_valid      = 1'b0;
    i_req_paddr      = '0;
    i_ext_req_ready  = 1'b0;
    i_ext_resp_valid = 1'b0;
    i_ext_resp_tag   = '0;
    i_ext_resp_data  = '0;
    model_valid      = '0;
    build_table();
    repeat (2) @(posedge i_clk);
    #2;
    i_reset_n = 1'b1;
    #1;
    check_value("reset outputs", '0,
                {o_ext_req_valid, o_wr_valid, o_resolve_valid, o_lrq_full});
    @(posedge i_clk);
    #2;

    for (int i = 0; i < n_rows; i++) begin
      r    = rows[i];
      name = $sformatf("%s row %0d", r.op.name(), i);
      case (r.op)
        OP_REQ: begin
          i_req_valid = 1'b1;
          i_req_paddr = r.addr;
          #1;
          check_value({name, " lrq_full"}, &model_valid, o_lrq_full);
          check_value({name, " conflict"}, r.exp_conflict, o_req_conflict);
          check_value({name, " full"}, r.exp_full, o_req_full);
          check_value({name, " index"}, r.exp_oh, o_req_index_oh);
          @(posedge i_clk);
          if (!r.exp_conflict && !r.exp_full) begin
            idx = oh_to_idx(r.exp_oh);
            model_valid[idx] = 1'b1;
            model_line[idx]  = r.addr[`LRQ_PADDR_W-1:OFFSET_W];
          end
          #2;
          i_req_valid = 1'b0;
        end
        OP_SEND: begin
          i_ext_req_ready = r.ready;
          wait_valid(1'b0);
          check_value({name, " read address"}, r.addr, o_ext_req_paddr);
          check_value({name, " read tag"}, r.tag, o_ext_req_tag);
          @(posedge i_clk);
          #2;
          i_ext_req_ready = 1'b0;
        end
        OP_RESP: begin
          i_ext_resp_valid = 1'b1;
          i_ext_resp_tag   = r.tag;
          i_ext_resp_data  = r.data;
          #1;
          check_value({name, " resolve"}, |r.exp_oh, o_resolve_valid);
          check_value({name, " resolve index"}, r.exp_oh, o_resolve_index_oh);
          @(posedge i_clk);
          #2;
          i_ext_resp_valid = 1'b0;
        end
        default: begin
          wait_valid(1'b1);
          idx = oh_to_idx(r.exp_oh);
          check_value({name, " write address"}, {model_line[idx], {OFFSET_W{1'b0}}},
                      o_wr_paddr);
          check_value({name, " write data"}, r.data, o_wr_data);
          @(posedge i_clk);
          model_valid[idx] = 1'b0;
          #2;
        end
      endcase
    end

    #1;
    check_value("final lrq_full", &model_valid, o_lrq_full);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/lrq_pkg.sv
design/lrq_alloc.sv
design/lrq_entry_array.sv
design/lrq_ext_port.sv
design/l1d_miss_unit.sv
test/tb_l1d_miss_unit.sv

// ==== Makefile ====
TOP = tb_l1d_miss_unit
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
